//--- biu_ahb_pkg.sv
/*
 * encodings, conversions and bundles shared by the core-side BIU and the
 * AHB3-Lite bus. prot flags are one-hot bits, and combinations are cast
 * into biu_prot_t. DWORD needs a 64 bit bus
 */
package biu_ahb_pkg;

  //////////////////////////////////////////////////////////////////////
  // core side encodings
  typedef enum logic [2:0] {BYTE = 3'd0, HWORD = 3'd1, WORD = 3'd2, DWORD = 3'd3} biu_size_t;

  typedef enum logic [2:0] {
    SINGLE, INCR, WRAP4, INCR4, WRAP8, INCR8, WRAP16, INCR16
  } biu_type_t;

  typedef enum logic [2:0] {
    PROT_DATA       = 3'b001,   // data access, else opcode fetch
    PROT_PRIVILEGED = 3'b010,
    PROT_CACHEABLE  = 3'b100
  } biu_prot_t;

  //////////////////////////////////////////////////////////////////////
  // AHB3-Lite encodings
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [2:0] HBURST_SINGLE = 3'b000;
  localparam logic [2:0] HBURST_INCR   = 3'b001;
  localparam logic [2:0] HBURST_WRAP4  = 3'b010;
  localparam logic [2:0] HBURST_INCR4  = 3'b011;
  localparam logic [2:0] HBURST_WRAP8  = 3'b100;
  localparam logic [2:0] HBURST_INCR8  = 3'b101;
  localparam logic [2:0] HBURST_WRAP16 = 3'b110;
  localparam logic [2:0] HBURST_INCR16 = 3'b111;

  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;
  localparam logic [2:0] HSIZE_DWORD = 3'b011;

  localparam logic [3:0] HPROT_DATA       = 4'b0001;
  localparam logic [3:0] HPROT_PRIVILEGED = 4'b0010;
  localparam logic [3:0] HPROT_CACHEABLE  = 4'b1000;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // bundles
  typedef struct packed {
    biu_size_t size;
    biu_type_t btype;          // burst type
    biu_prot_t prot;
    logic      lock;
    logic      we;
  } biu_req_t;                 // 11 bits

  typedef struct packed {
    logic       hsel;
    logic       hwrite;
    logic [2:0] hsize;
    logic [2:0] hburst;
    logic [3:0] hprot;
    logic [1:0] htrans;
    logic       hmastlock;
  } ahb_ctrl_t;                // 15 bits

  // bus control while parked
  localparam ahb_ctrl_t AHB_CTRL_IDLE = '{hsel: 1'b0, hwrite: 1'b0, hsize: HSIZE_WORD,
                                          hburst: HBURST_SINGLE,
                                          hprot: HPROT_DATA | HPROT_PRIVILEGED,
                                          htrans: HTRANS_IDLE, hmastlock: 1'b0};

  //////////////////////////////////////////////////////////////////////
  // core to bus conversions
  function automatic logic [2:0] biu_size2hsize(input biu_size_t size);
    case (size)
      BYTE   : return HSIZE_BYTE;
      HWORD  : return HSIZE_HWORD;
      DWORD  : return HSIZE_DWORD;
      default: return HSIZE_WORD;
    endcase
  endfunction

  function automatic logic [2:0] biu_type2hburst(input biu_type_t btype);
    case (btype)
      INCR   : return HBURST_INCR;
      WRAP4  : return HBURST_WRAP4;
      INCR4  : return HBURST_INCR4;
      WRAP8  : return HBURST_WRAP8;
      INCR8  : return HBURST_INCR8;
      WRAP16 : return HBURST_WRAP16;
      INCR16 : return HBURST_INCR16;
      default: return HBURST_SINGLE;
    endcase
  endfunction

  // beats minus one, undefined INCR runs as a single beat
  function automatic logic [3:0] biu_type2cnt(input biu_type_t btype);
    case (btype)
      WRAP4, INCR4  : return 4'd3;
      WRAP8, INCR8  : return 4'd7;
      WRAP16, INCR16: return 4'd15;
      default       : return 4'd0;
    endcase
  endfunction

  function automatic logic [3:0] biu_prot2hprot(input biu_prot_t prot);
    logic [3:0] hprot;
    hprot = 4'b0000;                                           // opcode, user, non-cacheable
    if (|(prot & PROT_DATA))       hprot = hprot | HPROT_DATA;
    if (|(prot & PROT_PRIVILEGED)) hprot = hprot | HPROT_PRIVILEGED;
    if (|(prot & PROT_CACHEABLE))  hprot = hprot | HPROT_CACHEABLE;
    return hprot;                                              // never bufferable
  endfunction

endpackage

//--- biu_ahb3lite.sv
`timescale 1ns/1ps
/*
 * core strobe to AHB3-Lite master. request fields are held with biu_stb_i
 * until biu_stb_ack_o, and each biu_d_ack_o takes biu_d_i for the beat it
 * issues. an ERROR response aborts the burst and also drops a request that
 * was accepted during the failing beat. INCR runs as a single beat
 */
module biu_ahb3lite
  import biu_ahb_pkg::*;
#(
  parameter int DATA_SIZE = 32,
  parameter int ADDR_SIZE = 32
)
(
  input  logic                 HCLK,
  input  logic                 HRESETn,

  // AHB3-Lite master side
  output logic [ADDR_SIZE-1:0] haddr_o,
  output ahb_ctrl_t            hctrl_o,
  output logic [DATA_SIZE-1:0] hwdata_o,
  input  logic [DATA_SIZE-1:0] hrdata_i,
  input  logic                 hready_i,
  input  logic                 hresp_i,

  // core side
  input  logic                 biu_stb_i,      // request strobe
  input  biu_req_t             biu_req_i,
  input  logic [ADDR_SIZE-1:0] biu_adri_i,     // start address
  input  logic [DATA_SIZE-1:0] biu_d_i,        // write data, one beat
  output logic                 biu_stb_ack_o,  // request taken
  output logic                 biu_d_ack_o,    // write data taken
  output logic [ADDR_SIZE-1:0] biu_adro_o,     // address of acked beat
  output logic [DATA_SIZE-1:0] biu_q_o,
  output logic                 biu_ack_o,      // beat done
  output logic                 biu_err_o       // bus error
);

  localparam int BUS_BYTES = DATA_SIZE / 8;
  localparam logic [ADDR_SIZE-1:0] LANE_MASK = ADDR_SIZE'(BUS_BYTES - 1);

  //////////////////////////////////////////////////////////////////////
  // next beat address
  // steps by the bus width, wrapping bursts stay inside their block
  function automatic logic [ADDR_SIZE-1:0] nxt_addr(input logic [ADDR_SIZE-1:0] addr,
                                                    input logic [2:0]           hburst);
    logic [ADDR_SIZE-1:0] lin;
    logic [ADDR_SIZE-1:0] wmask;
    lin = (addr + ADDR_SIZE'(BUS_BYTES)) & ~LANE_MASK;
    case (hburst)
      HBURST_WRAP4 : wmask = ADDR_SIZE'(4 * BUS_BYTES - 1);
      HBURST_WRAP8 : wmask = ADDR_SIZE'(8 * BUS_BYTES - 1);
      HBURST_WRAP16: wmask = ADDR_SIZE'(16 * BUS_BYTES - 1);
      default      : wmask = '1;                            // plain increment
    endcase
    return (addr & ~wmask) | (lin & wmask);
  endfunction

  logic [3:0]           burst_cnt;   // beats left after current
  logic                 burst_done;
  logic                 data_ena;    // address phase carries a beat
  logic                 ddata_ena;   // data phase carries a beat
  logic [DATA_SIZE-1:0] wdata_q;     // first write data stage

  assign burst_done = (burst_cnt == 4'd0);

  // new request only between bursts and not while reporting an error
  assign biu_stb_ack_o = hready_i & burst_done & biu_stb_i & ~biu_err_o;

  // every issued beat takes its write data
  assign biu_d_ack_o = biu_stb_ack_o | (hready_i & ~burst_done);

  //////////////////////////////////////////////////////////////////////
  // address phase
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      burst_cnt <= 4'd0;
      data_ena  <= 1'b0;
      biu_err_o <= 1'b0;
      haddr_o   <= '0;
      hctrl_o   <= AHB_CTRL_IDLE;
    end
    else
    begin
      biu_err_o <= 1'b0;                                   // one cycle pulse

      if (hready_i)
      begin
        if (!burst_done)
        begin
          // continue the burst
          data_ena       <= 1'b1;
          burst_cnt      <= burst_cnt - 4'd1;
          hctrl_o.htrans <= HTRANS_SEQ;
          haddr_o        <= nxt_addr(haddr_o, hctrl_o.hburst);
        end
        else if (biu_stb_ack_o)
        begin
          // start of a new transfer
          data_ena  <= 1'b1;
          burst_cnt <= biu_type2cnt(biu_req_i.btype);
          haddr_o   <= biu_adri_i;
          hctrl_o   <= '{hsel:      1'b1,
                         hwrite:    biu_req_i.we,
                         hsize:     biu_size2hsize(biu_req_i.size),
                         hburst:    biu_type2hburst(biu_req_i.btype),
                         hprot:     biu_prot2hprot(biu_req_i.prot),
                         htrans:    HTRANS_NONSEQ,
                         hmastlock: biu_req_i.lock};
        end
        else
        begin
          data_ena          <= 1'b0;
          hctrl_o.hsel      <= 1'b0;
          hctrl_o.htrans    <= HTRANS_IDLE;
          hctrl_o.hmastlock <= biu_req_i.lock;             // lock may span idle cycles
        end
      end
      else if (hresp_i == HRESP_ERROR)
      begin
        // first error cycle, cancel whatever is pending
        burst_cnt      <= 4'd0;
        data_ena       <= 1'b0;
        hctrl_o.hsel   <= 1'b0;
        hctrl_o.htrans <= HTRANS_IDLE;
        biu_err_o      <= 1'b1;
      end
      // wait states hold everything
    end

  //////////////////////////////////////////////////////////////////////
  // data phase
  always_ff @(posedge HCLK)
    if (biu_d_ack_o)
      wdata_q <= biu_d_i;

  // second stage lines up with the data phase
  always_ff @(posedge HCLK)
    if (hready_i)
    begin
      hwdata_o   <= wdata_q;
      biu_adro_o <= haddr_o;                               // beat address follows
    end

  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
      ddata_ena <= 1'b0;
    else if (hready_i)
      ddata_ena <= data_ena;

  // a failing beat is never acknowledged
  assign biu_ack_o = hready_i & ddata_ena & (hresp_i == HRESP_OKAY);
  assign biu_q_o   = hrdata_i;

endmodule

//--- ahb_sram_slave.sv
`timescale 1ns/1ps
/*
 * word organized SRAM on AHB3-Lite with a window from address 0.
 * MEM_WORDS is a power of two, HPROT and HMASTLOCK are ignored.
 * every beat costs WAIT_STATES cycles, out of window answers ERROR
 * in two cycles. read data is valid only while HREADY is high
 */
module ahb_sram_slave
  import biu_ahb_pkg::*;
#(
  parameter int DATA_SIZE   = 32,
  parameter int ADDR_SIZE   = 32,
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 1
)
(
  input  logic                 HCLK,
  input  logic                 HRESETn,

  input  logic [ADDR_SIZE-1:0] haddr_i,
  input  ahb_ctrl_t            hctrl_i,
  input  logic [DATA_SIZE-1:0] hwdata_i,
  output logic [DATA_SIZE-1:0] hrdata_o,
  output logic                 hready_o,
  output logic                 hresp_o
);

  localparam int BUS_BYTES = DATA_SIZE / 8;
  localparam int ADDR_LSB  = $clog2(BUS_BYTES);
  localparam int IDX_W     = $clog2(MEM_WORDS);
  localparam int WCNT_W    = $clog2(WAIT_STATES + 2);    // also holds the error count
  localparam logic [ADDR_SIZE-1:0] MEM_BYTES = ADDR_SIZE'(MEM_WORDS * BUS_BYTES);

  // byte lanes of a transfer
  function automatic logic [BUS_BYTES-1:0] lane_mask(input logic [2:0]          hsize,
                                                     input logic [ADDR_LSB-1:0] lo);
    logic [BUS_BYTES-1:0] base;
    case (hsize)
      HSIZE_BYTE : base = BUS_BYTES'(1);
      HSIZE_HWORD: base = BUS_BYTES'(3);
      HSIZE_WORD : base = BUS_BYTES'(15);
      default    : base = '1;                              // full bus
    endcase
    return base << lo;
  endfunction

  logic [DATA_SIZE-1:0] mem [MEM_WORDS];

  logic                 ap_valid;    // NONSEQ or SEQ selected
  logic                 ap_oow;      // outside the window
  logic                 dp_act;      // data phase in progress
  logic                 dp_err;
  logic                 dp_write;
  logic [2:0]           dp_size;
  logic [ADDR_SIZE-1:0] dp_addr;
  logic [IDX_W-1:0]     dp_idx;
  logic [WCNT_W-1:0]    wait_cnt;    // cycles left with HREADY low
  logic [BUS_BYTES-1:0] byte_en;
  logic                 mem_we;

  assign ap_valid = hctrl_i.hsel & hctrl_i.htrans[1];
  assign ap_oow   = (haddr_i >= MEM_BYTES);

  //////////////////////////////////////////////////////////////////////
  // address phase capture and wait state count
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      dp_act   <= 1'b0;
      dp_err   <= 1'b0;
      wait_cnt <= '0;
    end
    else if (hready_o)
    begin
      dp_act <= ap_valid;                                  // IDLE ends the data phase
      dp_err <= ap_valid & ap_oow;
      if (ap_valid & ap_oow)
        wait_cnt <= WCNT_W'(1);                            // ERROR, low then high
      else if (ap_valid)
        wait_cnt <= WCNT_W'(WAIT_STATES);
      else
        wait_cnt <= '0;
    end
    else
      wait_cnt <= wait_cnt - WCNT_W'(1);

  always_ff @(posedge HCLK)
    if (hready_o & ap_valid)
    begin
      dp_addr  <= haddr_i;
      dp_write <= hctrl_i.hwrite;
      dp_size  <= hctrl_i.hsize;
    end

  assign hready_o = (wait_cnt == '0);
  assign hresp_o  = dp_err ? HRESP_ERROR : HRESP_OKAY;

  //////////////////////////////////////////////////////////////////////
  // storage
  assign dp_idx  = dp_addr[ADDR_LSB +: IDX_W];
  assign byte_en = lane_mask(dp_size, dp_addr[ADDR_LSB-1:0]);
  assign mem_we  = hready_o & dp_act & dp_write & ~dp_err;   // last data phase cycle

  always_ff @(posedge HCLK)
    if (mem_we)
    begin
      for (int b = 0; b < BUS_BYTES; b++)
        if (byte_en[b])
          mem[dp_idx][8*b +: 8] <= hwdata_i[8*b +: 8];
    end

  // whole word back, the master picks its lanes
  assign hrdata_o = (dp_act & ~dp_err) ? mem[dp_idx] : '0;

endmodule

//--- biu_ahb_subsys.sv
`timescale 1ns/1ps
/*
 * single master AHB3-Lite subsystem, BIU driving one SRAM slave.
 * no decoder or mux, the slave is always selected by the BIU's hsel
 */
module biu_ahb_subsys
  import biu_ahb_pkg::*;
#(
  parameter int DATA_SIZE   = 32,
  parameter int ADDR_SIZE   = 32,
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 1
)
(
  input  logic                 HCLK,
  input  logic                 HRESETn,

  input  logic                 biu_stb_i,
  input  biu_req_t             biu_req_i,
  input  logic [ADDR_SIZE-1:0] biu_adri_i,
  input  logic [DATA_SIZE-1:0] biu_d_i,
  output logic                 biu_stb_ack_o,
  output logic                 biu_d_ack_o,
  output logic [ADDR_SIZE-1:0] biu_adro_o,
  output logic [DATA_SIZE-1:0] biu_q_o,
  output logic                 biu_ack_o,
  output logic                 biu_err_o
);

  //////////////////////////////////////////////////////////////////////
  // bus wires
  logic [ADDR_SIZE-1:0] haddr;
  ahb_ctrl_t            hctrl;
  logic [DATA_SIZE-1:0] hwdata;
  logic [DATA_SIZE-1:0] hrdata;
  logic                 hready;     // slave ready, fed straight back
  logic                 hresp;

  biu_ahb3lite #(
    .DATA_SIZE (DATA_SIZE),
    .ADDR_SIZE (ADDR_SIZE)
  ) i_biu (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .haddr_o       (haddr),
    .hctrl_o       (hctrl),
    .hwdata_o      (hwdata),
    .hrdata_i      (hrdata),
    .hready_i      (hready),
    .hresp_i       (hresp),
    .biu_stb_i     (biu_stb_i),
    .biu_req_i     (biu_req_i),
    .biu_adri_i    (biu_adri_i),
    .biu_d_i       (biu_d_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_adro_o    (biu_adro_o),
    .biu_q_o       (biu_q_o),
    .biu_ack_o     (biu_ack_o),
    .biu_err_o     (biu_err_o)
  );

  ahb_sram_slave #(
    .DATA_SIZE   (DATA_SIZE),
    .ADDR_SIZE   (ADDR_SIZE),
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) i_sram (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .haddr_i  (haddr),
    .hctrl_i  (hctrl),
    .hwdata_i (hwdata),
    .hrdata_o (hrdata),
    .hready_o (hready),
    .hresp_o  (hresp)
  );

endmodule

//--- biu_ahb_properties.sv
`timescale 1ns/1ps
/*
 * bus and core handshake properties of the BIU, bound into every
 * biu_ahb3lite instance. nothing is checked while HRESETn is low
 */
module biu_ahb_properties
  import biu_ahb_pkg::*;
#(
  parameter int ADDR_SIZE = 32
)
(
  input logic                 HCLK,
  input logic                 HRESETn,
  input logic [ADDR_SIZE-1:0] haddr_o,
  input ahb_ctrl_t            hctrl_o,
  input logic                 hready_i,
  input logic                 hresp_i,
  input logic                 biu_stb_ack_o,
  input logic                 biu_err_o
);

  logic [3:0] beats_left;   // owed after the previous beat
  logic [3:0] left_now;     // owed after the beat on the bus

  // beats minus one of an HBURST code, INCR counts as single
  function automatic logic [3:0] hburst_len(input logic [2:0] hburst);
    case (hburst)
      HBURST_WRAP4, HBURST_INCR4  : return 4'd3;
      HBURST_WRAP8, HBURST_INCR8  : return 4'd7;
      HBURST_WRAP16, HBURST_INCR16: return 4'd15;
      default                     : return 4'd0;
    endcase
  endfunction

  assign left_now = (hctrl_o.htrans == HTRANS_NONSEQ) ? hburst_len(hctrl_o.hburst) :
                    (hctrl_o.htrans == HTRANS_SEQ)    ? beats_left : 4'd0;

  // counts down once per accepted address phase
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
      beats_left <= 4'd0;
    else if (hready_i)
      beats_left <= (left_now != 4'd0) ? left_now - 4'd1 : 4'd0;

  // a burst never resumes from IDLE
  seq_after_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    hctrl_o.htrans == HTRANS_IDLE |=> hctrl_o.htrans != HTRANS_SEQ)
    else $error("SEQ issued right after IDLE");

  // wait states freeze the address phase, an ERROR may cancel it
  addr_phase_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!hready_i && hresp_i == HRESP_OKAY && hctrl_o.htrans != HTRANS_IDLE)
      |=> $stable(haddr_o) && $stable(hctrl_o))
    else $error("address phase changed while HREADY low");

  // a new request waits for the last beat of a burst
  stb_ack_between_bursts: assert property (@(posedge HCLK) disable iff (!HRESETn)
    biu_stb_ack_o |-> left_now == 4'd0)
    else $error("request taken with burst beats left");

  err_after_error_resp: assert property (@(posedge HCLK) disable iff (!HRESETn)
    biu_err_o |-> $past(hresp_i == HRESP_ERROR && !hready_i))
    else $error("biu_err_o without first ERROR cycle");

endmodule

bind biu_ahb3lite biu_ahb_properties #(
  .ADDR_SIZE (ADDR_SIZE)
) i_props (
  .HCLK          (HCLK),
  .HRESETn       (HRESETn),
  .haddr_o       (haddr_o),
  .hctrl_o       (hctrl_o),
  .hready_i      (hready_i),
  .hresp_i       (hresp_i),
  .biu_stb_ack_o (biu_stb_ack_o),
  .biu_err_o     (biu_err_o)
);

//--- biu_ahb_tb.sv
`timescale 1ns/1ps
/*
 * drives the core side of the AHB subsystem one request at a time and
 * checks every beat against a word model of the SRAM. reads only touch
 * words written earlier in the table, outputs are sampled on the falling edge
 */
module biu_ahb_tb
  import biu_ahb_pkg::*;
();

  localparam int DATA_SIZE   = 32;
  localparam int ADDR_SIZE   = 32;
  localparam int MEM_WORDS   = 256;
  localparam int WAIT_STATES = 1;
  localparam int MEM_BYTES   = MEM_WORDS * DATA_SIZE / 8;
  localparam int TIMEOUT     = 64;             // cycles per wait
  localparam int NUM_ROWS    = 23;

  typedef struct packed {
    biu_req_t             req;
    logic [ADDR_SIZE-1:0] addr;                // start address
    logic [DATA_SIZE-1:0] seed;                // fixed write data, 0 for random
    logic                 err;                 // bus error expected
  } row_t;

  logic                 HCLK;
  logic                 HRESETn;
  logic                 biu_stb_i;
  biu_req_t             biu_req_i;
  logic [ADDR_SIZE-1:0] biu_adri_i;
  logic [DATA_SIZE-1:0] biu_d_i;
  logic                 biu_stb_ack_o;
  logic                 biu_d_ack_o;
  logic [ADDR_SIZE-1:0] biu_adro_o;
  logic [DATA_SIZE-1:0] biu_q_o;
  logic                 biu_ack_o;
  logic                 biu_err_o;

  row_t                 rows [NUM_ROWS];
  logic [DATA_SIZE-1:0] ref_mem [MEM_WORDS];   // expected SRAM contents
  logic [DATA_SIZE-1:0] beat_data [16];
  int                   d_idx;                 // beats of write data taken
  logic                 smp_stb_ack;
  logic                 smp_d_ack;
  logic                 smp_ack;
  logic                 smp_err;
  int                   err_cnt;
  int                   fail_tests;
  int                   tests_run;
  bit                   timed_out;

  initial
  begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;                   // 4 ns period
  end

  biu_ahb_subsys #(
    .DATA_SIZE   (DATA_SIZE),
    .ADDR_SIZE   (ADDR_SIZE),
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) i_dut (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb_i),
    .biu_req_i     (biu_req_i),
    .biu_adri_i    (biu_adri_i),
    .biu_d_i       (biu_d_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_adro_o    (biu_adro_o),
    .biu_q_o       (biu_q_o),
    .biu_ack_o     (biu_ack_o),
    .biu_err_o     (biu_err_o)
  );

  //////////////////////////////////////////////////////////////////////
  // reference rules
  function automatic row_t make_row(input biu_size_t sz, input biu_type_t bt, input logic we,
                                    input logic [ADDR_SIZE-1:0] addr,
                                    input logic [DATA_SIZE-1:0] seed, input logic err);
    row_t r;
    r.req  = '{size: sz, btype: bt, prot: PROT_DATA, lock: 1'b0, we: we};
    r.addr = addr;
    r.seed = seed;
    r.err  = err;
    return r;
  endfunction

  function automatic int beat_count(input biu_type_t bt);
    case (bt)
      WRAP4, INCR4  : return 4;
      WRAP8, INCR8  : return 8;
      WRAP16, INCR16: return 16;
      default       : return 1;                // SINGLE and INCR
    endcase
  endfunction

  // k-th beat, wrapping bursts stay inside beats*4 bytes
  function automatic logic [ADDR_SIZE-1:0] beat_addr(input row_t r, input int k);
    logic [ADDR_SIZE-1:0] blk;
    blk = ADDR_SIZE'(4 * beat_count(r.req.btype));
    if (r.req.btype inside {WRAP4, WRAP8, WRAP16})
      return (r.addr / blk) * blk + (r.addr + ADDR_SIZE'(4 * k)) % blk;
    return r.addr + ADDR_SIZE'(4 * k);
  endfunction

  // only the lanes picked by size and low address bits
  function automatic void model_write(input biu_size_t sz, input logic [ADDR_SIZE-1:0] a,
                                      input logic [DATA_SIZE-1:0] d);
    int nbytes;
    int lo;
    nbytes = (sz == BYTE) ? 1 : (sz == HWORD) ? 2 : 4;
    lo     = int'(a[1:0]);
    for (int b = lo; b < lo + nbytes; b++)
      ref_mem[(a >> 2) % MEM_WORDS][8*b +: 8] = d[8*b +: 8];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  task automatic check_data(input string name, input logic [DATA_SIZE-1:0] exp,
                            input logic [DATA_SIZE-1:0] act);
    if (act !== exp)
    begin
      $display("Error: %s expected %h got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_SIZE-1:0] exp,
                            input logic [ADDR_SIZE-1:0] act);
    if (act !== exp)
    begin
      $display("Error: %s expected %h got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Error: %s expected %h got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_idle_outputs();
    check_err("biu_ack_o", 1'b0, biu_ack_o);
    check_err("biu_d_ack_o", 1'b0, biu_d_ack_o);
    check_err("biu_stb_ack_o", 1'b0, biu_stb_ack_o);
    check_err("biu_err_o", 1'b0, biu_err_o);
  endtask

  //////////////////////////////////////////////////////////////////////
  // one clock: drive on the rising edge, sample on the falling edge
  task automatic sample_outputs();
    smp_stb_ack = biu_stb_ack_o;
    smp_d_ack   = biu_d_ack_o;
    smp_ack     = biu_ack_o;
    smp_err     = biu_err_o;
  endtask

  task automatic tick();
    @(posedge HCLK);
    if (smp_stb_ack)
      biu_stb_i <= 1'b0;                       // request was taken on this edge
    if (smp_d_ack)
    begin
      d_idx = d_idx + 1;
      biu_d_i <= (d_idx < 16) ? beat_data[d_idx] : '0;   // next beat
    end
    @(negedge HCLK);
    sample_outputs();
  endtask

  task automatic wait_accept(output bit ok);
    int n;
    n = 0;
    while (!smp_stb_ack && n < TIMEOUT)
    begin
      tick();
      n++;
    end
    ok = smp_stb_ack;
    if (!ok)
    begin
      $display("timeout, biu_stb_ack_o did not come within %0d cycles", TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  // next acknowledge or error
  task automatic wait_beat(output bit ok);
    int n;
    n = 0;
    do
    begin
      tick();
      n++;
    end
    while (!smp_ack && !smp_err && n < TIMEOUT);
    ok = smp_ack | smp_err;
    if (!ok)
    begin
      $display("timeout, neither biu_ack_o nor biu_err_o within %0d cycles", TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // one table row
  task automatic run_row(input int t, input row_t r);
    int                   n_beats;
    int                   n_ok;                // leading beats inside the window
    int                   acks;
    int                   errs_before;
    bit                   got;
    bit                   err_seen;
    biu_type_t            bt;
    logic [ADDR_SIZE-1:0] a;
    errs_before = err_cnt;
    bt          = r.req.btype;
    n_beats     = beat_count(bt);
    n_ok        = 0;
    while (n_ok < n_beats && beat_addr(r, n_ok) < MEM_BYTES)
      n_ok++;
    for (int k = 0; k < 16; k++)
      beat_data[k] = (r.seed != '0) ? r.seed : $urandom();
    d_idx = 0;

    @(posedge HCLK);
    biu_stb_i  <= 1'b1;
    biu_req_i  <= r.req;
    biu_adri_i <= r.addr;
    biu_d_i    <= beat_data[0];
    @(negedge HCLK);
    sample_outputs();
    wait_accept(got);

    acks     = 0;
    err_seen = 1'b0;
    while (got && !err_seen && acks < n_beats)
    begin
      wait_beat(got);
      if (got && smp_ack)
      begin
        a = beat_addr(r, acks);
        check_addr("biu_adro_o", a, biu_adro_o);
        if (r.req.we)
          model_write(r.req.size, a, beat_data[acks]);
        else
          check_data("biu_q_o", ref_mem[(a >> 2) % MEM_WORDS], biu_q_o);
        acks++;
      end
      if (got && smp_err)
        err_seen = 1'b1;
    end

    if (got)
    begin
      if (acks != n_ok)
      begin
        $display("Error: biu_ack_o beats expected %h got %h", n_ok, acks);
        err_cnt++;
      end
      check_err("biu_err_o", r.err, err_seen);
      tick();                                  // burst over, nothing trails
      check_err("biu_ack_o", 1'b0, smp_ack);
      check_err("biu_err_o", 1'b0, smp_err);
    end

    tests_run++;
    if (got && err_cnt == errs_before)
      $display("test %0d %s %s at %h ok", t, bt.name(), r.req.we ? "write" : "read", r.addr);
    else
    begin
      $display("test %0d %s %s at %h failed", t, bt.name(), r.req.we ? "write" : "read",
               r.addr);
      fail_tests++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  task automatic fill_table();
    rows[0]  = make_row(WORD,  SINGLE, 1'b1, 32'h010, '0, 1'b0);   // word write and read
    rows[1]  = make_row(WORD,  SINGLE, 1'b0, 32'h010, '0, 1'b0);
    rows[2]  = make_row(WORD,  SINGLE, 1'b1, 32'h0a4, '0, 1'b0);
    rows[3]  = make_row(WORD,  SINGLE, 1'b1, 32'h3fc, '0, 1'b0);   // last word in window
    rows[4]  = make_row(WORD,  SINGLE, 1'b0, 32'h0a4, '0, 1'b0);
    rows[5]  = make_row(WORD,  SINGLE, 1'b0, 32'h3fc, '0, 1'b0);
    rows[6]  = make_row(WORD,  SINGLE, 1'b1, 32'h020, 32'h11223344, 1'b0);  // known word
    rows[7]  = make_row(BYTE,  SINGLE, 1'b1, 32'h021, '0, 1'b0);
    rows[8]  = make_row(HWORD, SINGLE, 1'b1, 32'h022, '0, 1'b0);
    rows[9]  = make_row(WORD,  SINGLE, 1'b0, 32'h020, '0, 1'b0);
    rows[10] = make_row(WORD,  INCR4,  1'b1, 32'h040, '0, 1'b0);
    rows[11] = make_row(WORD,  INCR4,  1'b0, 32'h040, '0, 1'b0);
    rows[12] = make_row(WORD,  INCR8,  1'b1, 32'h080, '0, 1'b0);
    rows[13] = make_row(WORD,  INCR8,  1'b0, 32'h080, '0, 1'b0);
    rows[14] = make_row(WORD,  WRAP4,  1'b1, 32'h0c8, '0, 1'b0);   // wraps to 0c0
    rows[15] = make_row(WORD,  WRAP4,  1'b0, 32'h0c4, '0, 1'b0);
    rows[16] = make_row(WORD,  WRAP8,  1'b1, 32'h0e8, '0, 1'b0);   // block 0e0..0ff
    rows[17] = make_row(WORD,  WRAP8,  1'b0, 32'h0f4, '0, 1'b0);
    rows[18] = make_row(WORD,  SINGLE, 1'b0, 32'h400, '0, 1'b1);   // past the window
    rows[19] = make_row(WORD,  INCR4,  1'b1, 32'h3f8, '0, 1'b1);   // third beat fails
    rows[20] = make_row(WORD,  SINGLE, 1'b0, 32'h3f8, '0, 1'b0);
    rows[21] = make_row(WORD,  INCR4,  1'b0, 32'h3f8, '0, 1'b1);
    rows[22] = make_row(WORD,  SINGLE, 1'b0, 32'h010, '0, 1'b0);
  endtask

  initial
  begin
    HRESETn    = 1'b0;
    biu_stb_i  = 1'b0;
    biu_req_i  = '0;
    biu_adri_i = '0;
    biu_d_i    = '0;
    void'($urandom(32'hf13a));
    smp_stb_ack = 1'b0;
    smp_d_ack   = 1'b0;
    smp_ack     = 1'b0;
    smp_err     = 1'b0;
    err_cnt     = 0;
    fail_tests  = 0;
    tests_run   = 0;
    timed_out   = 1'b0;
    d_idx       = 0;
    fill_table();

    // reset state, during and right after
    repeat (8)
    begin
      @(negedge HCLK);
      check_idle_outputs();
    end
    @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    check_idle_outputs();
    tests_run++;
    if (err_cnt == 0)
      $display("test 0 reset ok");
    else
    begin
      $display("test 0 reset failed");
      fail_tests++;
    end

    for (int t = 0; t < NUM_ROWS && !timed_out; t++)
      run_row(t + 1, rows[t]);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, fail_tests, err_cnt);
    if (fail_tests == 0 && err_cnt == 0 && !timed_out)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- compile.f
biu_ahb_pkg.sv
biu_ahb3lite.sv
ahb_sram_slave.sv
biu_ahb_subsys.sv
biu_ahb_properties.sv
biu_ahb_tb.sv

//--- Makefile
# Verilator build and run of the BIU AHB subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= biu_ahb_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
